/* include/regdec_params.svh */
// width, register count and rv64 major opcode macros for the decode stage
`ifndef REGDEC_PARAMS_SVH
`define REGDEC_PARAMS_SVH

// register and immediate width
`define XLEN        64
// raw instruction word
`define INSTR_W     32
// integer register file depth
`define NUM_REGS    32
`define REG_IDX_W   5
// funct3 followed by the 7-bit opcode
`define FUNC_OP_W   10

// major opcodes, instruction bits 6..0
`define OPC_OP       7'b0110011
`define OPC_OP32     7'b0111011
`define OPC_LOAD     7'b0000011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP_IMM32 7'b0011011
`define OPC_STORE    7'b0100011
`define OPC_BRANCH   7'b1100011
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
// fence and fence.i
`define OPC_MISC_MEM 7'b0001111
`define OPC_SYSTEM   7'b1110011

`endif

/* register_decode.f */
+incdir+include
verilog/regdec_pkg.sv
verilog/decoded_if.sv
verilog/instr_capture.sv
verilog/field_decode.sv
verilog/operand_fetch.sv
verilog/result_handoff.sv
verilog/register_decode.sv
verification/tb_clock_gen.sv
verification/register_decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the decode stage testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f register_decode.f \
    --top-module register_decode_tb \
    -o register_decode_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/register_decode_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

/* verification/register_decode_tb.sv */
// stimulus, reference decoder, result compare and report for the decode stage
`timescale 1ns/1ps
`include "regdec_params.svh"

module register_decode_tb
    import regdec_pkg::*;
;

    // run length estimate for the watchdog
    localparam int NUM_INSTR        = 92;
    localparam int NUM_WRITES       = 32;
    localparam int CYCLES_PER_INSTR = 20;
    localparam int HOLD_CYCLES      = 10;
    localparam int CYCLE_LIMIT      = 2 * (4 + NUM_INSTR * CYCLES_PER_INSTR
                                           + NUM_WRITES * 2 + HOLD_CYCLES);

    logic                  clk;
    logic                  reset;
    logic [`INSTR_W-1:0]   instr;
    logic                  instr_req;
    logic                  instr_ack;
    logic [`XLEN-1:0]      rd_data_a;
    logic [`XLEN-1:0]      rd_data_b;
    logic [`REG_IDX_W-1:0] rd;
    logic [`FUNC_OP_W-1:0] funct_opcode;
    logic [`XLEN-1:0]      imm;
    logic                  illegal;
    logic                  out_req;
    logic                  out_ack;
    logic                  wr_en;
    logic [`REG_IDX_W-1:0] wr_reg;
    logic [`XLEN-1:0]      wr_data;

    // shadow register file with x0 never written
    logic [`XLEN-1:0]      shadow [`NUM_REGS];
    // sent words in send order
    logic [`INSTR_W-1:0]   pending [$];
    logic [6:0]            kept_opc [13] = '{`OPC_OP, `OPC_OP32, `OPC_LOAD, `OPC_OP_IMM,
                                             `OPC_OP_IMM32, `OPC_STORE, `OPC_BRANCH,
                                             `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
                                             `OPC_MISC_MEM, `OPC_SYSTEM};

    int  errors       = 0;
    int  tests_failed = 0;
    int  test_errors  = 0;
    int  n_sent       = 0;
    int  n_done       = 0;
    int  cycles       = 0;
    // consumer withholds ack while set
    logic ack_hold    = 1'b0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    register_decode DUT (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_req    (instr_req),
        .instr_ack    (instr_ack),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .rd           (rd),
        .funct_opcode (funct_opcode),
        .imm          (imm),
        .illegal      (illegal),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .wr_en        (wr_en),
        .wr_reg       (wr_reg),
        .wr_data      (wr_data)
    );

    // expected bundle straight from the rv64 format rules
    function automatic void ref_decode(
        input  logic [31:0] w,
        output logic [63:0] a,
        output logic [63:0] b,
        output logic [63:0] im,
        output logic [4:0]  dst,
        output logic [9:0]  fo,
        output logic        ill
    );
        logic [6:0] opc;
        logic       use_a;
        logic       use_b;
        opc   = w[6:0];
        use_a = 1'b0;
        use_b = 1'b0;
        im    = '0;
        dst   = w[11:7];
        fo    = {w[14:12], opc};
        ill   = 1'b0;
        case (opc)
            `OPC_OP, `OPC_OP32: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            `OPC_LOAD, `OPC_OP_IMM, `OPC_OP_IMM32, `OPC_JALR, `OPC_SYSTEM: begin
                use_a = 1'b1;
                im    = {{52{w[31]}}, w[31:20]};
            end
            `OPC_STORE: begin
                use_a = 1'b1;
                use_b = 1'b1;
                dst   = '0;
                im    = {{52{w[31]}}, w[31:25], w[11:7]};
            end
            `OPC_BRANCH: begin
                use_a = 1'b1;
                use_b = 1'b1;
                dst   = '0;
                im    = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            `OPC_LUI, `OPC_AUIPC: begin
                fo = {3'b000, opc};
                im = {{32{w[31]}}, w[31:12], 12'b0};
            end
            `OPC_JAL: begin
                fo = {3'b000, opc};
                im = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            `OPC_MISC_MEM: begin
                dst = '0;
                im  = {{52{w[31]}}, w[31:20]};
            end
            default: begin
                ill = 1'b1;
                dst = '0;
            end
        endcase
        // shadow[0] stays zero
        a = use_a ? shadow[w[19:15]] : '0;
        b = use_b ? shadow[w[24:20]] : '0;
    endfunction

    function automatic logic known_opcode(input logic [6:0] opc);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < 13; k++) begin
            if (kept_opc[k] == opc) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // random fields under a fixed opcode
    function automatic instr_word_u random_instr(input logic [6:0] opc);
        instr_word_u w;
        logic [31:0] r;
        r = $urandom;
        w = r;
        w.r.opcode = opc;
        return w;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic fail_note(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic write_reg(input logic [4:0] r, input logic [63:0] d);
        wr_en   = 1'b1;
        wr_reg  = r;
        wr_data = d;
        @(negedge clk);
        wr_en = 1'b0;
        if (r != 5'd0) begin
            shadow[r] = d;
        end
    endtask

    // full four-phase source cycle starting on a falling edge
    task automatic send_instr(input logic [31:0] w);
        pending.push_back(w);
        n_sent++;
        instr     = w;
        instr_req = 1'b1;
        do @(negedge clk); while (!instr_ack);
        instr_req = 1'b0;
        do @(negedge clk); while (instr_ack);
    endtask

    task automatic wait_results();
        while (n_done < n_sent) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input int num, input string name);
        int delta;
        delta = errors - test_errors;
        if (delta == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, delta);
            tests_failed++;
        end
        test_errors = errors;
    endtask

    // consumer checks each bundle on req, acks it, drops ack after req falls
    initial begin
        logic [31:0] w;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] ei;
        logic [4:0]  erd;
        logic [9:0]  efo;
        logic        eill;
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req && !out_ack && !ack_hold) begin
                if (pending.size() == 0) begin
                    fail_note("result presented with no instruction outstanding");
                end else begin
                    w = pending.pop_front();
                    ref_decode(w, ea, eb, ei, erd, efo, eill);
                    check("rd_data_a", rd_data_a, ea);
                    check("rd_data_b", rd_data_b, eb);
                    check("rd", 64'(rd), 64'(erd));
                    check("funct_opcode", 64'(funct_opcode), 64'(efo));
                    check("imm", imm, ei);
                    check("illegal", 64'(illegal), 64'(eill));
                end
                out_ack = 1'b1;
            end else if (out_ack && !out_req) begin
                out_ack = 1'b0;
                n_done++;
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles, %0d of %0d results back",
                     cycles, n_done, n_sent);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        instr_word_u w;
        logic [31:0] r;
        logic [6:0]  opc;
        int          done_before;
        void'($urandom(32'hc1d3_3125));
        instr     = '0;
        instr_req = 1'b0;
        wr_en     = 1'b0;
        wr_reg    = '0;
        wr_data   = '0;
        for (int k = 0; k < `NUM_REGS; k++) begin
            shadow[k] = '0;
        end

        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end

        // test 1 checks idle handshakes and cleared registers
        check("instr_ack", 64'(instr_ack), 64'd0);
        check("out_req", 64'(out_req), 64'd0);
        send_instr(random_instr(`OPC_OP));
        wait_results();
        end_test(1, "reset state");

        // test 2 fills every register including x0 and reads back in pairs
        for (int k = 0; k < `NUM_REGS; k++) begin
            write_reg(k[4:0], {$urandom, $urandom});
        end
        for (int k = 0; k < `NUM_REGS / 2; k++) begin
            w = random_instr(`OPC_OP);
            w.r.rs1 = 5'(2 * k);
            w.r.rs2 = 5'(2 * k + 1);
            send_instr(w);
        end
        wait_results();
        end_test(2, "register write and read");

        // test 3 sends four random words per kept opcode
        for (int k = 0; k < 13; k++) begin
            for (int n = 0; n < 4; n++) begin
                send_instr(random_instr(kept_opc[k]));
            end
        end
        wait_results();
        end_test(3, "opcode classes");

        // test 4 uses opcodes off the list
        for (int n = 0; n < 20; n++) begin
            do begin
                r   = $urandom;
                opc = r[6:0];
            end while (known_opcode(opc));
            send_instr(random_instr(opc));
        end
        wait_results();
        end_test(4, "illegal opcodes");

        // test 5 stalls the output until slot and holding register fill up
        done_before = n_done;
        ack_hold = 1'b1;
        send_instr(random_instr(`OPC_BRANCH));
        send_instr(random_instr(`OPC_STORE));
        w = random_instr(`OPC_OP32);
        pending.push_back(w);
        n_sent++;
        instr     = w;
        instr_req = 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (instr_ack) begin
                fail_note("third request acknowledged while the output was stalled");
            end
        end
        ack_hold = 1'b0;
        do @(negedge clk); while (!instr_ack);
        if (n_done <= done_before) begin
            fail_note("third request acknowledged before the first result completed");
        end
        instr_req = 1'b0;
        do @(negedge clk); while (instr_ack);
        wait_results();
        end_test(5, "back-pressure");

        $display("tests run 5, tests failed %0d, errors %0d, results %0d",
                 tests_failed, errors, n_done);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
// testbench clock source and power-on reset pulse
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held over four rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* verilog/decoded_if.sv */
// decoded bundle link from operand fetch to result handoff
`timescale 1ns/1ps
`include "regdec_params.svh"

interface decoded_if;

    // slot full
    logic                  valid;
    // one-cycle pulse, frees the slot
    logic                  taken;

    // bundle payload, stable while valid
    logic [`XLEN-1:0]      rd_data_a;
    logic [`XLEN-1:0]      rd_data_b;
    logic [`REG_IDX_W-1:0] rd;
    logic [`FUNC_OP_W-1:0] funct_opcode;
    logic [`XLEN-1:0]      imm;
    logic                  illegal;

    // fetch side fills the slot
    modport source (
        output valid,
        output rd_data_a,
        output rd_data_b,
        output rd,
        output funct_opcode,
        output imm,
        output illegal,
        input  taken
    );

    // handoff side drains it
    modport sink (
        input  valid,
        input  rd_data_a,
        input  rd_data_b,
        input  rd,
        input  funct_opcode,
        input  imm,
        input  illegal,
        output taken
    );

endinterface

/* verilog/field_decode.sv */
// opcode classification, register field selection and immediate build
`timescale 1ns/1ps
`include "regdec_params.svh"

module field_decode
    import regdec_pkg::*;
(
    input  instr_word_u           instr,
    output logic [`REG_IDX_W-1:0] rs1,
    output logic [`REG_IDX_W-1:0] rs2,
    output logic                  rs1_used,
    output logic                  rs2_used,
    output logic [`REG_IDX_W-1:0] rd,
    output logic [`FUNC_OP_W-1:0] funct_opcode,
    output logic [`XLEN-1:0]      imm,
    output logic                  illegal
);

    // sign-extended immediates, one per format
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    // bits 31..20
    assign imm_i = {{(`XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};

    // upper 7 and lower 5 split by rs2/rs1/funct3
    assign imm_s = {{(`XLEN-12){instr.s.imm_11_5[6]}},
                    instr.s.imm_11_5, instr.s.imm_4_0};

    // 13-bit offset, halfword aligned
    assign imm_b = {{(`XLEN-13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};

    // upper 20 bits, low 12 cleared, then rv64 sign extension
    assign imm_u = {{(`XLEN-32){instr.u.imm_31_12[19]}}, instr.u.imm_31_12, 12'b0};

    // 21-bit jump offset, halfword aligned
    assign imm_j = {{(`XLEN-21){instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    always_comb begin
        // unread ports and unused fields default to zero
        rs1          = '0;
        rs2          = '0;
        rs1_used     = 1'b0;
        rs2_used     = 1'b0;
        rd           = instr.r.rd;
        funct_opcode = {instr.r.funct3, instr.r.opcode};
        imm          = '0;
        illegal      = 1'b0;

        case (instr.r.opcode)
            `OPC_OP, `OPC_OP32: begin
                // two sources, no immediate
                rs1      = instr.r.rs1;
                rs2      = instr.r.rs2;
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            `OPC_LOAD, `OPC_OP_IMM, `OPC_OP_IMM32, `OPC_JALR, `OPC_SYSTEM: begin
                // jalr shares the plain i layout
                rs1      = instr.i.rs1;
                rs1_used = 1'b1;
                imm      = imm_i;
            end
            `OPC_STORE: begin
                // bits 11..7 hold imm, not rd
                rs1      = instr.s.rs1;
                rs2      = instr.s.rs2;
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                rd       = '0;
                imm      = imm_s;
            end
            `OPC_BRANCH: begin
                rs1      = instr.b.rs1;
                rs2      = instr.b.rs2;
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                rd       = '0;
                imm      = imm_b;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                // no funct3 in u format
                rd           = instr.u.rd;
                funct_opcode = {3'b000, instr.u.opcode};
                imm          = imm_u;
            end
            `OPC_JAL: begin
                rd           = instr.j.rd;
                funct_opcode = {3'b000, instr.j.opcode};
                imm          = imm_j;
            end
            `OPC_MISC_MEM: begin
                // fence: pred/succ bits in imm, nothing written back
                rd  = '0;
                imm = imm_i;
            end
            default: begin
                // unknown major opcode
                illegal = 1'b1;
                rd      = '0;
            end
        endcase
    end

endmodule

/* verilog/instr_capture.sv */
// four-phase instruction receiver with a one-entry holding register
`timescale 1ns/1ps

module instr_capture
    import regdec_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  instr_word_u instr,
    input  logic        instr_req,
    input  logic        held_take,
    output logic        instr_ack,
    output logic        held_valid,
    output instr_word_u held_instr
);

    // receiver handshake states
    typedef enum logic {
        CAP_IDLE,
        CAP_ACK
    } cap_state_e;

    cap_state_e state;
    logic       capture;

    // only take a word when the holding slot is empty
    assign capture = (state == CAP_IDLE) && instr_req && !held_valid;

    // ack is high for the whole of the ack phase
    assign instr_ack = (state == CAP_ACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= CAP_IDLE;
        end else begin
            case (state)
                CAP_IDLE: begin
                    if (capture) begin
                        state <= CAP_ACK;
                    end
                end
                CAP_ACK: begin
                    // source drops req first, then we release ack
                    if (!instr_req) begin
                        state <= CAP_IDLE;
                    end
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

    // slot occupancy
    // capture and take never coincide, take needs a full slot
    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (capture) begin
            held_valid <= 1'b1;
        end else if (held_take) begin
            held_valid <= 1'b0;
        end
    end

    // word latched on the capturing edge
    always_ff @(posedge clk) begin
        if (capture) begin
            held_instr <= instr;
        end
    end

endmodule

/* verilog/operand_fetch.sv */
// register file, writeback port and decoded bundle register
`timescale 1ns/1ps
`include "regdec_params.svh"

module operand_fetch
    import regdec_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  held_valid,
    input  instr_word_u           held_instr,
    input  logic                  wr_en,
    input  logic [`REG_IDX_W-1:0] wr_reg,
    input  logic [`XLEN-1:0]      wr_data,
    output logic                  held_take,
    decoded_if.source             dec
);

    // x0..x31
    logic [`XLEN-1:0]      regs [`NUM_REGS];

    // decoder outputs
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic                  rs1_used;
    logic                  rs2_used;
    logic [`REG_IDX_W-1:0] rd;
    logic [`FUNC_OP_W-1:0] funct_opcode;
    logic [`XLEN-1:0]      imm;
    logic                  illegal;

    logic [`XLEN-1:0]      read_a;
    logic [`XLEN-1:0]      read_b;
    logic                  slot_free;

    field_decode u_field_decode (
        .instr        (held_instr),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_used     (rs1_used),
        .rs2_used     (rs2_used),
        .rd           (rd),
        .funct_opcode (funct_opcode),
        .imm          (imm),
        .illegal      (illegal)
    );

    // unused ports read zero; x0 is never written so reads zero too
    assign read_a = rs1_used ? regs[rs1] : '0;
    assign read_b = rs2_used ? regs[rs2] : '0;

    // slot can refill on the same edge it is released
    assign slot_free = !dec.valid || dec.taken;
    assign held_take = held_valid && slot_free;

    // writeback, x0 writes dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en && (wr_reg != '0)) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // output slot state
    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else if (held_take) begin
            dec.valid <= 1'b1;
        end else if (dec.taken) begin
            dec.valid <= 1'b0;
        end
    end

    // bundle payload, reads see pre-edge contents
    always_ff @(posedge clk) begin
        if (held_take) begin
            dec.rd_data_a    <= read_a;
            dec.rd_data_b    <= read_b;
            dec.rd           <= rd;
            dec.funct_opcode <= funct_opcode;
            dec.imm          <= imm;
            dec.illegal      <= illegal;
        end
    end

endmodule

/* verilog/regdec_pkg.sv */
// instruction word union with r, i, s, b, u and j format views
`include "regdec_params.svh"

package regdec_pkg;

    // one 32-bit word, six ways of slicing it
    typedef union packed {
        // register-register ops
        struct packed {
            logic [6:0]            funct7;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        // loads, alu immediates, jalr, system
        struct packed {
            logic [11:0]           imm_11_0;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
        // stores, immediate split around rs fields
        struct packed {
            logic [6:0]            imm_11_5;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_4_0;
            logic [6:0]            opcode;
        } s;
        // branches, bit 0 of the offset implied zero
        struct packed {
            logic                  imm_12;
            logic [5:0]            imm_10_5;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [3:0]            imm_4_1;
            logic                  imm_11;
            logic [6:0]            opcode;
        } b;
        // lui / auipc
        struct packed {
            logic [19:0]           imm_31_12;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } u;
        // jal, scrambled 20-bit offset
        struct packed {
            logic                  imm_20;
            logic [9:0]            imm_10_1;
            logic                  imm_11;
            logic [7:0]            imm_19_12;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } j;
    } instr_word_u;

endpackage

/* verilog/register_decode.sv */
// decode stage top: capture, operand fetch and result handoff
`timescale 1ns/1ps
`include "regdec_params.svh"

module register_decode
    import regdec_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // instruction link
    input  logic [`INSTR_W-1:0]   instr,
    input  logic                  instr_req,
    output logic                  instr_ack,
    // result link
    output logic [`XLEN-1:0]      rd_data_a,
    output logic [`XLEN-1:0]      rd_data_b,
    output logic [`REG_IDX_W-1:0] rd,
    output logic [`FUNC_OP_W-1:0] funct_opcode,
    output logic [`XLEN-1:0]      imm,
    output logic                  illegal,
    output logic                  out_req,
    input  logic                  out_ack,
    // writeback port
    input  logic                  wr_en,
    input  logic [`REG_IDX_W-1:0] wr_reg,
    input  logic [`XLEN-1:0]      wr_data
);

    // holding register to fetch
    logic        held_valid;
    instr_word_u held_instr;
    logic        held_take;

    // fetch to handoff
    decoded_if dec_link ();

    instr_capture u_instr_capture (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instr_req  (instr_req),
        .held_take  (held_take),
        .instr_ack  (instr_ack),
        .held_valid (held_valid),
        .held_instr (held_instr)
    );

    operand_fetch u_operand_fetch (
        .clk        (clk),
        .reset      (reset),
        .held_valid (held_valid),
        .held_instr (held_instr),
        .wr_en      (wr_en),
        .wr_reg     (wr_reg),
        .wr_data    (wr_data),
        .held_take  (held_take),
        .dec        (dec_link)
    );

    result_handoff u_result_handoff (
        .clk          (clk),
        .reset        (reset),
        .out_ack      (out_ack),
        .dec          (dec_link),
        .out_req      (out_req),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .rd           (rd),
        .funct_opcode (funct_opcode),
        .imm          (imm),
        .illegal      (illegal)
    );

endmodule

/* verilog/result_handoff.sv */
// four-phase sender that presents decoded bundles downstream
`timescale 1ns/1ps
`include "regdec_params.svh"

module result_handoff (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  out_ack,
    decoded_if.sink               dec,
    output logic                  out_req,
    output logic [`XLEN-1:0]      rd_data_a,
    output logic [`XLEN-1:0]      rd_data_b,
    output logic [`REG_IDX_W-1:0] rd,
    output logic [`FUNC_OP_W-1:0] funct_opcode,
    output logic [`XLEN-1:0]      imm,
    output logic                  illegal
);

    // sender handshake states
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_RELEASE
    } hs_state_e;

    hs_state_e state;

    assign out_req = (state == HS_REQ);

    // exchange done once the consumer drops ack
    // combinational so the slot clears before idle looks at valid again
    assign dec.taken = (state == HS_RELEASE) && !out_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (dec.valid) begin
                        state <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (out_ack) begin
                        state <= HS_RELEASE;
                    end
                end
                HS_RELEASE: begin
                    if (!out_ack) begin
                        state <= HS_IDLE;
                    end
                end
                default: begin
                    state <= HS_IDLE;
                end
            endcase
        end
    end

    // bundle held in the slot register upstream
    assign rd_data_a    = dec.rd_data_a;
    assign rd_data_b    = dec.rd_data_b;
    assign rd           = dec.rd;
    assign funct_opcode = dec.funct_opcode;
    assign imm          = dec.imm;
    assign illegal      = dec.illegal;

endmodule
